// ==== source/rv_pkg.sv ====
package rv_pkg;

  // Base ISA widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // Return stack sizing
  localparam int ras_depth = 8;
  localparam int ras_ptr_w = $clog2(ras_depth);

  // ra and t0 act as link registers
  localparam logic [reg_addr_w-1:0] link_reg     = 5'd1;
  localparam logic [reg_addr_w-1:0] link_reg_alt = 5'd5;

  // Major opcodes, instruction bits 6:2
  typedef enum logic [4:0] {
    OP_LOAD   = 5'b00000,
    OP_FENCE  = 5'b00011,
    OP_IMM    = 5'b00100,
    OP_AUIPC  = 5'b00101,
    OP_STORE  = 5'b01000,
    OP_REG    = 5'b01100,
    OP_LUI    = 5'b01101,
    OP_BRANCH = 5'b11000,
    OP_JALR   = 5'b11001,
    OP_JAL    = 5'b11011,
    OP_SYSTEM = 5'b11100
  } opcode_e;

  typedef enum logic [2:0] {
    FMT_NONE,
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_U,
    FMT_B,
    FMT_J
  } inst_format_e;

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  // Same encoding as funct3 of a branch
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_cond_e;

endpackage

// ==== source/decode_if.sv ====
`timescale 1ns/100ps

// Registered decode results shared by the decoder and the return stack
interface decode_if
  import rv_pkg::*;
();

  logic            valid;     // One-cycle pulse per decoded instruction
  logic            push;      // Return stack hints
  logic            pop;
  logic [xlen-1:0] link_addr; // pc + 4
  logic [xlen-1:0] pc;

  modport producer (
    output valid,
    output push,
    output pop,
    output link_addr,
    output pc
  );

  modport consumer (
    input valid,
    input push,
    input pop,
    input link_addr,
    input pc
  );

endinterface

// ==== source/rv_decode.sv ====
`timescale 1ns/100ps

module rv_decode
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  clear_i,
  input  logic                  data_ready_i,
  input  logic [xlen-1:0]       instruction_i,
  input  logic [xlen-1:0]       pc_i,
  decode_if.producer            dec,
  output inst_format_e          fmt_o,
  output alu_op_e               alu_op_o,
  output logic [reg_addr_w-1:0] rs1_addr_o,
  output logic [reg_addr_w-1:0] rs2_addr_o,
  output logic [reg_addr_w-1:0] rd_addr_o,
  output logic [xlen-1:0]       imm_o,
  output logic                  imm_valid_o,
  output logic [2:0]            word_size_o,
  output logic                  jal_jump_o,
  output logic [xlen-1:0]       jal_target_o,
  output logic                  jalr_o,
  output logic                  branch_o,
  output branch_cond_e          branch_cond_o
);

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic                  funct7_b5;
  logic [reg_addr_w-1:0] rs1_f, rs2_f, rd_f;

  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [xlen-1:0] link_addr;

  inst_format_e          fmt_d;
  alu_op_e               alu_d;
  logic [reg_addr_w-1:0] rs1_d, rs2_d, rd_d;
  logic [xlen-1:0]       imm_d;
  logic                  imm_valid_d;
  logic [2:0]            word_size_d;
  logic                  is_jal, is_jalr, is_branch, is_shift;
  logic                  rd_link, rs1_link;
  logic                  push_d, pop_d;
  logic                  accept;

  // Instruction fields
  assign opcode    = opcode_e'(instruction_i[6:2]);
  assign funct3    = instruction_i[14:12];
  assign funct7_b5 = instruction_i[30];
  assign rd_f      = instruction_i[11:7];
  assign rs1_f     = instruction_i[19:15];
  assign rs2_f     = instruction_i[24:20];

  assign imm_i = {{(xlen-12){instruction_i[31]}}, instruction_i[31:20]};
  assign imm_s = {{(xlen-12){instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
  assign imm_b = {{(xlen-13){instruction_i[31]}}, instruction_i[31], instruction_i[7],
                  instruction_i[30:25], instruction_i[11:8], 1'b0};
  assign imm_u = {instruction_i[31:12], 12'b0};
  assign imm_j = {{(xlen-21){instruction_i[31]}}, instruction_i[31], instruction_i[19:12],
                  instruction_i[20], instruction_i[30:21], 1'b0};

  assign link_addr = pc_i + xlen'(4);

  always_comb
  begin
    case (opcode)
      OP_LOAD, OP_FENCE, OP_IMM, OP_JALR, OP_SYSTEM: fmt_d = FMT_I;
      OP_AUIPC, OP_LUI: fmt_d = FMT_U;
      OP_STORE:         fmt_d = FMT_S;
      OP_REG:           fmt_d = FMT_R;
      OP_BRANCH:        fmt_d = FMT_B;
      OP_JAL:           fmt_d = FMT_J;
      default:          fmt_d = FMT_NONE;
    endcase
  end

  // Unused register fields read as x0
  always_comb
  begin
    rs1_d = '0;
    rs2_d = '0;
    rd_d  = '0;
    case (fmt_d)
      FMT_R:
      begin
        rs1_d = rs1_f;
        rs2_d = rs2_f;
        rd_d  = rd_f;
      end
      FMT_I:
      begin
        rs1_d = rs1_f;
        rd_d  = rd_f;
      end
      FMT_S, FMT_B:
      begin
        rs1_d = rs1_f;
        rs2_d = rs2_f;
      end
      FMT_U, FMT_J: rd_d = rd_f;
      default: rd_d = '0;
    endcase
  end

  always_comb
  begin
    case (opcode)
      OP_LUI:   imm_d = imm_u;
      OP_AUIPC: imm_d = imm_u + pc_i;
      OP_JAL:   imm_d = link_addr; // Value written to rd
      default:
      begin
        case (fmt_d)
          FMT_I:   imm_d = imm_i;
          FMT_S:   imm_d = imm_s;
          FMT_B:   imm_d = imm_b;
          default: imm_d = '0;
        endcase
      end
    endcase
  end

  assign imm_valid_d = (fmt_d != FMT_NONE) && (fmt_d != FMT_R);
  assign word_size_d = (opcode == OP_LOAD || opcode == OP_STORE) ? funct3 : 3'b000;

  // SLLI and SRLI/SRAI are the only immediate ops that look at funct7
  assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

  always_comb
  begin
    case (opcode)
      OP_REG:  alu_d = alu_op_e'({funct7_b5, funct3});
      OP_IMM:  alu_d = alu_op_e'({funct7_b5 & is_shift, funct3});
      default: alu_d = ALU_ADD;
    endcase
  end

  assign is_jal    = (opcode == OP_JAL);
  assign is_jalr   = (opcode == OP_JALR);
  assign is_branch = (opcode == OP_BRANCH);

  // Call and return hints
  assign rd_link  = (rd_f == link_reg) || (rd_f == link_reg_alt);
  assign rs1_link = (rs1_f == link_reg) || (rs1_f == link_reg_alt);
  assign push_d   = rd_link & (is_jal | is_jalr);
  assign pop_d    = is_jalr & rs1_link & (~rd_link | (rd_f != rs1_f)); // Same link reg: push only

  assign accept = data_ready_i & ~clear_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dec.valid   <= 1'b0;
      imm_valid_o <= 1'b0;
      jal_jump_o  <= 1'b0;
      jalr_o      <= 1'b0;
      branch_o    <= 1'b0;
    end
    else if (clear_i)
    begin
      dec.valid   <= 1'b0;
      imm_valid_o <= 1'b0;
      jal_jump_o  <= 1'b0;
      jalr_o      <= 1'b0;
      branch_o    <= 1'b0;
    end
    else
    begin
      dec.valid <= data_ready_i;
      if (data_ready_i)
      begin
        imm_valid_o <= imm_valid_d;
        jal_jump_o  <= is_jal;
        jalr_o      <= is_jalr;
        branch_o    <= is_branch;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      fmt_o         <= fmt_d;
      alu_op_o      <= alu_d;
      rs1_addr_o    <= rs1_d;
      rs2_addr_o    <= rs2_d;
      rd_addr_o     <= rd_d;
      imm_o         <= imm_d;
      word_size_o   <= word_size_d;
      jal_target_o  <= pc_i + imm_j;
      branch_cond_o <= is_branch ? branch_cond_e'(funct3) : BR_EQ;
      dec.push      <= push_d;
      dec.pop       <= pop_d;
      dec.link_addr <= link_addr;
      dec.pc        <= pc_i;
    end
  end

  a_imm_has_fmt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    imm_valid_o |-> fmt_o != FMT_NONE);

  a_ctrl_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({jal_jump_o, jalr_o, branch_o}));

endmodule

// ==== source/return_stack.sv ====
`timescale 1ns/100ps

module return_stack
  import rv_pkg::*;
(
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            clear_i,
  decode_if.consumer      dec,
  output logic            ras_valid_o,
  output logic [xlen-1:0] ras_target_o
);

  logic [xlen-1:0]      stack_mem [ras_depth];
  logic [ras_ptr_w-1:0] top_q;    // Index of the newest entry
  logic [ras_ptr_w-1:0] push_ptr;
  logic [ras_ptr_w:0]   count_q;
  logic                 empty, full;
  logic                 do_push, do_pop;

  assign empty    = (count_q == '0);
  assign full     = (count_q == (ras_ptr_w + 1)'(ras_depth));
  assign push_ptr = top_q + 1'b1; // Wraps onto the oldest entry when full

  assign do_push = dec.valid & dec.push & ~clear_i;
  assign do_pop  = dec.valid & dec.pop & ~empty & ~clear_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      top_q       <= '0;
      count_q     <= '0;
      ras_valid_o <= 1'b0;
    end
    else if (clear_i)
    begin
      top_q       <= '0;
      count_q     <= '0;
      ras_valid_o <= 1'b0;
    end
    else
    begin
      ras_valid_o <= do_pop;
      if (do_push && !do_pop)
      begin
        top_q <= push_ptr;
        if (!full)
          count_q <= count_q + 1'b1; // Saturates at depth
      end
      else if (do_pop && !do_push)
      begin
        top_q   <= top_q - 1'b1;
        count_q <= count_q - 1'b1;
      end
      // Pop then push leaves pointer and count alone
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (do_pop)
      ras_target_o <= stack_mem[top_q];
    if (do_push && do_pop)
      stack_mem[top_q] <= dec.link_addr; // Replace the popped entry
    else if (do_push)
      stack_mem[push_ptr] <= dec.link_addr;
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    count_q <= (ras_ptr_w + 1)'(ras_depth));

endmodule

// ==== source/rv_front_top.sv ====
`timescale 1ns/100ps

module rv_front_top
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  clear_i,
  input  logic                  data_ready_i,
  input  logic [xlen-1:0]       instruction_i,
  input  logic [xlen-1:0]       pc_i,
  output logic                  dec_valid_o,
  output inst_format_e          fmt_o,
  output alu_op_e               alu_op_o,
  output logic [reg_addr_w-1:0] rs1_addr_o,
  output logic [reg_addr_w-1:0] rs2_addr_o,
  output logic [reg_addr_w-1:0] rd_addr_o,
  output logic [xlen-1:0]       imm_o,
  output logic                  imm_valid_o,
  output logic [2:0]            word_size_o,
  output logic                  jal_jump_o,
  output logic [xlen-1:0]       jal_target_o,
  output logic                  jalr_o,
  output logic                  branch_o,
  output branch_cond_e          branch_cond_o,
  output logic                  ras_valid_o,
  output logic [xlen-1:0]       ras_target_o
);

  decode_if u_dec_if ();

  rv_decode u_rv_decode (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .clear_i       (clear_i),
    .data_ready_i  (data_ready_i),
    .instruction_i (instruction_i),
    .pc_i          (pc_i),
    .dec           (u_dec_if.producer),
    .fmt_o         (fmt_o),
    .alu_op_o      (alu_op_o),
    .rs1_addr_o    (rs1_addr_o),
    .rs2_addr_o    (rs2_addr_o),
    .rd_addr_o     (rd_addr_o),
    .imm_o         (imm_o),
    .imm_valid_o   (imm_valid_o),
    .word_size_o   (word_size_o),
    .jal_jump_o    (jal_jump_o),
    .jal_target_o  (jal_target_o),
    .jalr_o        (jalr_o),
    .branch_o      (branch_o),
    .branch_cond_o (branch_cond_o)
  );

  // Prediction lags decode by one cycle
  return_stack u_return_stack (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .clear_i      (clear_i),
    .dec          (u_dec_if.consumer),
    .ras_valid_o  (ras_valid_o),
    .ras_target_o (ras_target_o)
  );

  assign dec_valid_o = u_dec_if.valid;

endmodule

// ==== verif/tb_rv_front.sv ====
`timescale 1ns/100ps

module tb_rv_front
  import rv_pkg::*;
();

  typedef enum logic [1:0] {ROW_NORMAL, ROW_CLEAR, ROW_BACK2BACK} row_kind_e;

  typedef struct {
    row_kind_e             kind;
    logic [xlen-1:0]       instr;
    logic [xlen-1:0]       pc;
    inst_format_e          fmt;
    alu_op_e               alu;
    logic [reg_addr_w-1:0] rs1, rs2, rd;
    logic [xlen-1:0]       imm;
    logic [2:0]            ws;
    branch_cond_e          br;
    logic [2:0]            ctl;   // {jal, jalr, branch}
    logic [xlen-1:0]       jt;
    logic [xlen-1:0]       ras;   // Zero means no prediction expected
  } row_t;

  logic                  clk_i = 1'b0;
  logic                  arst_n_i, clear_i, data_ready_i;
  logic [xlen-1:0]       instruction_i, pc_i;
  logic                  dec_valid_o, imm_valid_o, jal_jump_o, jalr_o, branch_o, ras_valid_o;
  inst_format_e          fmt_o;
  alu_op_e               alu_op_o;
  branch_cond_e          branch_cond_o;
  logic [reg_addr_w-1:0] rs1_addr_o, rs2_addr_o, rd_addr_o;
  logic [xlen-1:0]       imm_o, jal_target_o, ras_target_o;
  logic [2:0]            word_size_o;

  row_t       rows[$];
  row_kind_e  next_kind = ROW_NORMAL;
  logic [7:0] lfsr = 8'd33;

  rv_front_top u_rv_front_top (.*);

  always #10 clk_i = ~clk_i;

  // Galois form, taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    logic [7:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 8'hb8;
    return n;
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_fmt(input string name, input inst_format_e exp, input inst_format_e act);
    if (act !== exp)
      fail_now($sformatf("FAILED at %0t: %s expected %s got %s", $time, name,
                         exp.name(), act.name()));
  endtask

  task automatic check_alu(input string name, input alu_op_e exp, input alu_op_e act);
    if (act !== exp)
      fail_now($sformatf("FAILED at %0t: %s expected %s got %s", $time, name,
                         exp.name(), act.name()));
  endtask

  task automatic check_br(input string name, input branch_cond_e exp, input branch_cond_e act);
    if (act !== exp)
      fail_now($sformatf("FAILED at %0t: %s expected %s got %s", $time, name,
                         exp.name(), act.name()));
  endtask

  task automatic check_reg(input string name, input logic [reg_addr_w-1:0] exp,
                           input logic [reg_addr_w-1:0] act);
    if (act !== exp)
      fail_now($sformatf("FAILED at %0t: %s expected x%0d got x%0d", $time, name, exp, act));
  endtask

  task automatic check_word(input string name, input logic [xlen-1:0] exp,
                            input logic [xlen-1:0] act);
    if (act !== exp)
      fail_now($sformatf("FAILED at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_now($sformatf("FAILED at %0t: %s expected %b got %b", $time, name, exp, act));
  endtask

  task automatic add_row(input logic [xlen-1:0] instr, input logic [xlen-1:0] pc,
                         input inst_format_e fmt, input alu_op_e alu,
                         input logic [reg_addr_w-1:0] rs1, input logic [reg_addr_w-1:0] rs2,
                         input logic [reg_addr_w-1:0] rd, input logic [xlen-1:0] imm,
                         input logic [2:0] ws, input branch_cond_e br, input logic [2:0] ctl,
                         input logic [xlen-1:0] jt, input logic [xlen-1:0] ras);
    row_t r;
    r = '{next_kind, instr, pc, fmt, alu, rs1, rs2, rd, imm, ws, br, ctl, jt, ras};
    rows.push_back(r);
    next_kind = ROW_NORMAL;
  endtask

  task automatic build_table();
    logic [xlen-1:0] pc;
    logic [xlen-1:0] ret;
    // ALU ops and register fields
    add_row(32'h002081b3, 'h100, FMT_R, ALU_ADD, 1, 2, 3, 0, 0, BR_EQ, 3'b000, 0, 0);
    add_row(32'h40628233, 'h104, FMT_R, ALU_SUB, 5, 6, 4, 0, 0, BR_EQ, 3'b000, 0, 0);
    add_row(32'h409453b3, 'h108, FMT_R, ALU_SRA, 8, 9, 7, 0, 0, BR_EQ, 3'b000, 0, 0);
    add_row(32'h4035d513, 'h10c, FMT_I, ALU_SRA, 11, 0, 10, 'h403, 0, BR_EQ, 3'b000, 0, 0);
    add_row(32'hfff6f613, 'h110, FMT_I, ALU_AND, 13, 0, 12, 'hffffffff, 0, BR_EQ, 3'b000, 0, 0);
    add_row(32'h4007b713, 'h114, FMT_I, ALU_SLTU, 15, 0, 14, 'h400, 0, BR_EQ, 3'b000, 0, 0);
    // Loads, stores, branches, upper immediates
    add_row(32'hff812803, 'h200, FMT_I, ALU_ADD, 2, 0, 16, 'hfffffff8, 2, BR_EQ, 3'b000, 0, 0);
    add_row(32'h8001d883, 'h204, FMT_I, ALU_ADD, 3, 0, 17, 'hfffff800, 5, BR_EQ, 3'b000, 0, 0);
    add_row(32'hff29ae23, 'h208, FMT_S, ALU_ADD, 19, 18, 0, 'hfffffffc, 2, BR_EQ, 3'b000, 0, 0);
    add_row(32'h014a82a3, 'h20c, FMT_S, ALU_ADD, 21, 20, 0, 5, 0, BR_EQ, 3'b000, 0, 0);
    add_row(32'hff7b4ce3, 'h210, FMT_B, ALU_ADD, 22, 23, 0, 'hfffffff8, 0, BR_LT, 3'b001, 0, 0);
    add_row(32'h119c7063, 'h214, FMT_B, ALU_ADD, 24, 25, 0, 'h100, 0, BR_GEU, 3'b001, 0, 0);
    add_row(32'h12345d37, 'h218, FMT_U, ALU_ADD, 0, 0, 26, 'h12345000, 0, BR_EQ, 3'b000, 0, 0);
    add_row(32'hfffffd97, 'h2000, FMT_U, ALU_ADD, 0, 0, 27, 'h1000, 0, BR_EQ, 3'b000, 0, 0);
    // Call to ra and its return
    add_row(32'h001000ef, 'h1000, FMT_J, ALU_ADD, 0, 0, 1, 'h1004, 0, BR_EQ, 3'b100, 'h1800, 0);
    add_row(32'h00008067, 'h1800, FMT_I, ALU_ADD, 1, 0, 0, 0, 0, BR_EQ, 3'b010, 0, 'h1004);
    // Nine nested calls, one more than the stack holds
    for (int k = 0; k < 9; k++)
    begin
      pc = 'h4000 + 'h100 * k;
      add_row(32'hff1ff0ef, pc, FMT_J, ALU_ADD, 0, 0, 1, pc + 4, 0, BR_EQ, 3'b100, pc - 16, 0);
    end
    for (int k = 0; k < 9; k++)
    begin
      pc = 'h5000 + 4 * k;
      ret = (k < 8) ? 'h4004 + 'h100 * (8 - k) : 0; // First call was overwritten
      add_row(32'h00008067, pc, FMT_I, ALU_ADD, 1, 0, 0, 0, 0, BR_EQ, 3'b010, 0, ret);
    end
    // Link register corner cases
    add_row(32'h001000ef, 'h6000, FMT_J, ALU_ADD, 0, 0, 1, 'h6004, 0, BR_EQ, 3'b100, 'h6800, 0);
    add_row(32'h000280e7, 'h6800, FMT_I, ALU_ADD, 5, 0, 1, 0, 0, BR_EQ, 3'b010, 0, 'h6004);
    add_row(32'h00008067, 'h7000, FMT_I, ALU_ADD, 1, 0, 0, 0, 0, BR_EQ, 3'b010, 0, 'h6804);
    add_row(32'h000080e7, 'h7100, FMT_I, ALU_ADD, 1, 0, 1, 0, 0, BR_EQ, 3'b010, 0, 0);
    add_row(32'h00008067, 'h7200, FMT_I, ALU_ADD, 1, 0, 0, 0, 0, BR_EQ, 3'b010, 0, 'h7104);
    add_row(32'h00028067, 'h7300, FMT_I, ALU_ADD, 5, 0, 0, 0, 0, BR_EQ, 3'b010, 0, 0);
    // Flush drops the call and empties the stack
    add_row(32'h001000ef, 'h8000, FMT_J, ALU_ADD, 0, 0, 1, 'h8004, 0, BR_EQ, 3'b100, 'h8800, 0);
    next_kind = ROW_CLEAR;
    add_row(32'h001000ef, 'h8100, FMT_J, ALU_ADD, 0, 0, 1, 'h8104, 0, BR_EQ, 3'b100, 'h8900, 0);
    add_row(32'h00008067, 'h8200, FMT_I, ALU_ADD, 1, 0, 0, 0, 0, BR_EQ, 3'b010, 0, 0);
    add_row(32'h002081b3, 'h9000, FMT_R, ALU_ADD, 1, 2, 3, 0, 0, BR_EQ, 3'b000, 0, 0);
    next_kind = ROW_BACK2BACK;
    add_row(32'h40628233, 'h9004, FMT_R, ALU_SUB, 5, 6, 4, 0, 0, BR_EQ, 3'b000, 0, 0);
    next_kind = ROW_BACK2BACK;
    add_row(32'h409453b3, 'h9008, FMT_R, ALU_SRA, 8, 9, 7, 0, 0, BR_EQ, 3'b000, 0, 0);
  endtask

  task automatic drive_rows();
    int gap;
    for (int i = 0; i < rows.size(); i++)
    begin
      gap = 0;
      for (int b = 0; b < 2; b++)
      begin
        lfsr = lfsr_next(lfsr);
        gap  = gap * 2 + int'(lfsr[0]);
      end
      if (rows[i].kind == ROW_BACK2BACK)
        gap = 0;
      else if (rows[i].kind == ROW_CLEAR)
        gap = gap + 2; // Let the previous prediction drain
      repeat (gap)
      begin
        @(posedge clk_i);
        data_ready_i <= 1'b0;
      end
      @(posedge clk_i);
      data_ready_i  <= 1'b1;
      clear_i       <= (rows[i].kind == ROW_CLEAR);
      instruction_i <= rows[i].instr;
      pc_i          <= rows[i].pc;
      if (rows[i].kind == ROW_CLEAR)
      begin
        @(posedge clk_i);
        data_ready_i <= 1'b0;
        clear_i      <= 1'b0;
        @(negedge clk_i);
        check_bit("dec_valid_o", 1'b0, dec_valid_o);
        check_bit("jal_jump_o", 1'b0, jal_jump_o);
      end
    end
    @(posedge clk_i);
    data_ready_i <= 1'b0;
  endtask

  task automatic wait_dec_valid(input int row);
    int cycles;
    cycles = 0;
    while (dec_valid_o !== 1'b1)
    begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 20)
        fail_now($sformatf("Row %0d never raised dec_valid_o within 20 cycles", row));
    end
  endtask

  task automatic check_rows();
    row_t r;
    @(negedge clk_i);
    foreach (rows[i])
    begin
      r = rows[i];
      if (r.kind != ROW_CLEAR)
      begin
        wait_dec_valid(i);
        check_fmt("fmt_o", r.fmt, fmt_o);
        check_alu("alu_op_o", r.alu, alu_op_o);
        check_reg("rs1_addr_o", r.rs1, rs1_addr_o);
        check_reg("rs2_addr_o", r.rs2, rs2_addr_o);
        check_reg("rd_addr_o", r.rd, rd_addr_o);
        check_bit("imm_valid_o", r.fmt != FMT_R, imm_valid_o);
        if (r.fmt != FMT_R)
          check_word("imm_o", r.imm, imm_o);
        check_word("word_size_o", xlen'(r.ws), xlen'(word_size_o));
        check_bit("jal_jump_o", r.ctl[2], jal_jump_o);
        check_bit("jalr_o", r.ctl[1], jalr_o);
        check_bit("branch_o", r.ctl[0], branch_o);
        if (r.ctl[2])
          check_word("jal_target_o", r.jt, jal_target_o);
        if (r.ctl[0])
          check_br("branch_cond_o", r.br, branch_cond_o);
        @(negedge clk_i); // Prediction trails decode by a cycle
        check_bit("ras_valid_o", r.ras != 0, ras_valid_o);
        if (r.ras != 0)
          check_word("ras_target_o", r.ras, ras_target_o);
      end
    end
  endtask

  initial
  begin
    arst_n_i      = 1'b0;
    clear_i       = 1'b0;
    data_ready_i  = 1'b0;
    instruction_i = '0;
    pc_i          = '0;
    build_table();
    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    fork
      drive_rows();
      check_rows();
    join
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== rv_front.f ====
source/rv_pkg.sv
source/decode_if.sv
source/rv_decode.sv
source/return_stack.sv
source/rv_front_top.sv
verif/tb_rv_front.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f rv_front.f \
  --top-module tb_rv_front \
  -Mdir obj_dir \
  -o sim_rv_front

# The simulator exits nonzero on $fatal, so grep the log to decide
./obj_dir/sim_rv_front > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
  exit 0
fi
exit 1
